//--- Bender.yml
package:
  name: bus_system

sources:
  - verilog/bus_pkg.sv
  - verilog/bus_master_port.sv
  - verilog/bus_arbiter.sv
  - verilog/mem_slave.sv
  - verilog/bus_system.sv
  - target: test
    files:
      - tb/bus_system_assertions.sv
      - tb/tb_bus_system.sv

//--- tb/bus_system_assertions.sv
// module bus_system_checks with bus protocol assertions, and its bind to bus_system

`timescale 1ns/100ps

module bus_system_checks (
	input logic       clk,
	input logic       rst_n,
	input logic       req0,
	input logic       req1,
	input logic       ack0,
	input logic       ack1,
	input logic       m0_request,
	input logic       m1_request,
	input logic [1:0] grant,
	input logic       s0_strobe,
	input logic       s1_strobe,
	input logic       s0_done,
	input logic       s1_done
);

	int   fail_count = 0;
	logic xfer_open;

	// one transfer in flight between a strobe and its done
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			xfer_open <= 1'b0;
		end else if (s0_strobe || s1_strobe) begin
			xfer_open <= 1'b1;
		end else if (s0_done || s1_done) begin
			xfer_open <= 1'b0;
		end
	end

	// the bus only goes to a master that is asking for it
	a_grant_request: assert property (@(posedge clk) disable iff (!rst_n)
		(!grant[0] || m0_request) && (!grant[1] || m1_request))
	else begin
		$error("bus granted to a master that is not requesting");
		fail_count++;
	end

	a_ack0_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack0) |-> $past(req0))
	else begin
		$error("ack0 rose without req0");
		fail_count++;
	end

	a_ack1_rise: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(ack1) |-> $past(req1))
	else begin
		$error("ack1 rose without req1");
		fail_count++;
	end

	a_ack0_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(ack0 && req0) |=> ack0)
	else begin
		$error("ack0 fell while req0 was still high");
		fail_count++;
	end

	a_ack1_hold: assert property (@(posedge clk) disable iff (!rst_n)
		(ack1 && req1) |=> ack1)
	else begin
		$error("ack1 fell while req1 was still high");
		fail_count++;
	end

	// no new strobe while a transfer is open
	a_strobe_idle: assert property (@(posedge clk) disable iff (!rst_n)
		(s0_strobe || s1_strobe) |-> !xfer_open)
	else begin
		$error("strobe while a transfer was still open");
		fail_count++;
	end

	a_done_open: assert property (@(posedge clk) disable iff (!rst_n)
		(s0_done || s1_done) |-> (xfer_open && !s0_strobe && !s1_strobe))
	else begin
		$error("done without an open transfer");
		fail_count++;
	end

	// delay is at most 15, so done comes within 16 cycles
	a_s0_answer: assert property (@(posedge clk) disable iff (!rst_n)
		s0_strobe |-> ##[1:16] s0_done)
	else begin
		$error("slave 0 gave no done after its strobe");
		fail_count++;
	end

	a_s1_answer: assert property (@(posedge clk) disable iff (!rst_n)
		s1_strobe |-> ##[1:16] s1_done)
	else begin
		$error("slave 1 gave no done after its strobe");
		fail_count++;
	end

	a_reset_quiet: assert property (@(posedge clk)
		$rose(rst_n) |-> !(ack0 || ack1 || m0_request || m1_request || (|grant)
			|| s0_strobe || s1_strobe || s0_done || s1_done))
	else begin
		$error("control output high in the first cycle after reset");
		fail_count++;
	end

endmodule

bind bus_system bus_system_checks u_checks (
	.clk        (clk),
	.rst_n      (rst_n),
	.req0       (req0),
	.req1       (req1),
	.ack0       (ack0),
	.ack1       (ack1),
	.m0_request (m0_request),
	.m1_request (m1_request),
	.grant      (u_arbiter.grant),
	.s0_strobe  (s0_strobe),
	.s1_strobe  (s1_strobe),
	.s0_done    (s0_done),
	.s1_done    (s1_done)
);

//--- tb/tb_bus_system.sv
// testbench tb_bus_system with xorshift stimulus, shadow memory checks and run timeout

`timescale 1ns/100ps

module tb_bus_system;

	localparam int unsigned SLAVE0_DELAY = 0;
	localparam int unsigned SLAVE1_DELAY = 10;
	localparam int CLK_PERIOD = 20;
	localparam int DRIVE_DELAY = 2;
	localparam int NUM_RANDOM = 40;
	// 80 contended accesses at up to about 30 cycles each, the short tests, and margin
	localparam int TIMEOUT_CYCLES = 3000;

	logic          clk;
	logic          rst_n;
	logic          req0;
	logic          req1;
	bus_pkg::cmd_t cmd0;
	bus_pkg::cmd_t cmd1;
	logic          ack0;
	logic          ack1;
	bus_pkg::rsp_t rsp0;
	bus_pkg::rsp_t rsp1;

	// expected word per slave, x until first written
	logic [bus_pkg::DATA_W-1:0] shadow [bus_pkg::NUM_SLAVES][1 << bus_pkg::ADDR_W];
	bus_pkg::cmd_t              rand_cmds [2][NUM_RANDOM];
	logic [31:0]                rng_state;
	int                         cycle_count = 0;
	int                         errors;
	int                         checks;
	int                         test_start_errors;
	int                         lat;

	bus_system #(
		.SLAVE0_DELAY (SLAVE0_DELAY),
		.SLAVE1_DELAY (SLAVE1_DELAY)
	) u_bus_system (
		.clk   (clk),
		.rst_n (rst_n),
		.req0  (req0),
		.req1  (req1),
		.cmd0  (cmd0),
		.cmd1  (cmd1),
		.ack0  (ack0),
		.ack1  (ack1),
		.rsp0  (rsp0),
		.rsp1  (rsp1)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
	end

	initial begin
		wait (cycle_count >= TIMEOUT_CYCLES);
		$display("run timed out after %0d cycles with transfers still pending", cycle_count);
		$display("Verification failed");
		$finish;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// own errors plus failed bus assertions
	function automatic int total_errors();
		return errors + u_bus_system.u_checks.fail_count;
	endfunction

	function automatic logic ack_of(input int port);
		return (port == 0) ? ack0 : ack1;
	endfunction

	function automatic bus_pkg::cmd_t make_cmd(input logic write, input logic slave,
		input logic [bus_pkg::ADDR_W-1:0] addr, input logic [bus_pkg::DATA_W-1:0] wdata);
		bus_pkg::cmd_t c;
		c.write = write;
		c.slave = slave;
		c.addr  = addr;
		c.wdata = wdata;
		return c;
	endfunction

	task automatic gen_cmds();
		for (int p = 0; p < 2; p++) begin
			for (int i = 0; i < NUM_RANDOM; i++) begin
				rng_state = xorshift32(rng_state);
				rand_cmds[p][i].write = rng_state[0];
				rand_cmds[p][i].slave = rng_state[1];
				// each master keeps to its own sixteen words
				rand_cmds[p][i].addr  = {p[0], 5'b00000, rng_state[7:4]};
				rand_cmds[p][i].wdata = rng_state[23:16];
			end
		end
	endtask

	task automatic drop_req(input int port);
		if (port == 0) begin
			req0 = 1'b0;
		end else begin
			req1 = 1'b0;
		end
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
		end while (ack_of(port));
	endtask

	// one four-phase access, hold keeps req high after ack
	task automatic do_access(input int port, input bus_pkg::cmd_t c, input bit hold,
		output int cycles);
		logic [bus_pkg::DATA_W-1:0] expected;
		bus_pkg::rsp_t              got;
		expected = shadow[c.slave][c.addr];
		if (c.write) begin
			shadow[c.slave][c.addr] = c.wdata;
		end
		if (port == 0) begin
			cmd0 = c;
			req0 = 1'b1;
		end else begin
			cmd1 = c;
			req1 = 1'b1;
		end
		cycles = 0;
		do begin
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end while (!ack_of(port));
		got = (port == 0) ? rsp0 : rsp1;
		if (!$isunknown(expected)) begin
			checks++;
			assert (got.rdata === expected) else begin
				$display("Mismatch at %0t: port %0d slave %0d addr %h returned %h, expected %h",
					$time, port, c.slave, c.addr, got.rdata, expected);
				errors++;
			end
		end
		if (!hold) begin
			drop_req(port);
		end
	endtask

	task automatic run_list(input int port, input int count, input int slave);
		bus_pkg::cmd_t c;
		int            l;
		for (int i = 0; i < count; i++) begin
			c = rand_cmds[port][i];
			// negative slave keeps the random choice
			if (slave >= 0) begin
				c.slave = slave[0];
			end
			do_access(port, c, 1'b0, l);
		end
	endtask

	task automatic check_latency(input int got, input int want);
		assert (got == want) else begin
			$display("Mismatch at %0t: ack came %0d cycles after req, expected %0d",
				$time, got, want);
			errors++;
		end
	endtask

	task automatic end_test(input int num, input string name);
		$display("test %0d %s: %0d errors", num, name, total_errors() - test_start_errors);
		test_start_errors = total_errors();
	endtask

	initial begin
		rst_n = 1'b0;
		req0 = 1'b0;
		req1 = 1'b0;
		cmd0 = '0;
		cmd1 = '0;
		rng_state = 32'h6b88;
		errors = 0;
		checks = 0;
		test_start_errors = 0;
		repeat (10) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;

		// test 1, quiet ports after reset
		repeat (5) begin
			@(posedge clk);
			#DRIVE_DELAY;
			assert (!ack0 && !ack1) else begin
				$display("Mismatch at %0t: ack high with no request", $time);
				errors++;
			end
		end
		end_test(1, "reset");

		// test 2, write twice then read back on slave 0
		do_access(0, make_cmd(1'b1, 1'b0, 10'h015, 8'h3c), 1'b0, lat);
		check_latency(lat, SLAVE0_DELAY + 4);
		do_access(0, make_cmd(1'b1, 1'b0, 10'h015, 8'hc3), 1'b0, lat);
		do_access(0, make_cmd(1'b0, 1'b0, 10'h015, 8'h00), 1'b0, lat);
		end_test(2, "write and read back");

		// test 3, same address in both slaves
		do_access(0, make_cmd(1'b1, 1'b0, 10'h120, 8'h5a), 1'b0, lat);
		do_access(1, make_cmd(1'b1, 1'b1, 10'h120, 8'ha5), 1'b0, lat);
		check_latency(lat, SLAVE1_DELAY + 4);
		do_access(0, make_cmd(1'b0, 1'b0, 10'h120, 8'h00), 1'b0, lat);
		do_access(1, make_cmd(1'b0, 1'b1, 10'h120, 8'h00), 1'b0, lat);
		end_test(3, "independent slaves");

		// test 4, both masters at once
		gen_cmds();
		fork
			run_list(0, NUM_RANDOM, -1);
			run_list(1, NUM_RANDOM, -1);
		join
		end_test(4, "concurrent random");

		// test 5, slow slave 1 next to busy slave 0
		gen_cmds();
		fork
			run_list(0, 20, 0);
			run_list(1, 6, 1);
		join
		end_test(5, "slow slave");

		// test 6, master 0 keeps req up while master 1 works
		gen_cmds();
		do_access(0, make_cmd(1'b1, 1'b0, 10'h00a, 8'h77), 1'b1, lat);
		run_list(1, 8, -1);
		assert (ack0 === 1'b1) else begin
			$display("Mismatch at %0t: ack0 dropped while req0 was held", $time);
			errors++;
		end
		drop_req(0);
		end_test(6, "held ack");

		$display("%0d data checks, %0d errors", checks, total_errors());
		if (total_errors() == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- verilog.f
verilog/bus_pkg.sv
verilog/bus_master_port.sv
verilog/bus_arbiter.sv
verilog/mem_slave.sv
verilog/bus_system.sv
tb/bus_system_assertions.sv
tb/tb_bus_system.sv

//--- verilog/bus_arbiter.sv
// module bus_arbiter with round-robin grant, slave routing and done return

`timescale 1ns/100ps

module bus_arbiter (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       m0_request,
	input  logic                       m1_request,
	input  bus_pkg::xfer_t             m0_xfer,
	input  bus_pkg::xfer_t             m1_xfer,
	output logic                       m0_done,
	output logic                       m1_done,
	output bus_pkg::rsp_t              m0_rsp,
	output bus_pkg::rsp_t              m1_rsp,
	output logic                       s0_strobe,
	output logic                       s1_strobe,
	output bus_pkg::xfer_t             s_xfer,
	input  logic                       s0_done,
	input  logic                       s1_done,
	input  logic [bus_pkg::DATA_W-1:0] s0_rdata,
	input  logic [bus_pkg::DATA_W-1:0] s1_rdata
);

	logic                       busy;
	logic                       owner;
	logic                       last_winner;
	logic                       pick;
	logic                       any_request;
	logic [1:0]                 grant;
	bus_pkg::xfer_t             pick_xfer;
	logic                       slave_done;
	logic [bus_pkg::DATA_W-1:0] slave_rdata;

	// round robin, the loser of the last round goes first on a tie
	always_comb begin
		any_request = m0_request | m1_request;
		if (m0_request && m1_request) begin
			pick = ~last_winner;
		end else begin
			pick = m1_request;
		end
	end

	assign pick_xfer = pick ? m1_xfer : m0_xfer;

	// owner holds its xfer steady until done
	assign s_xfer = owner ? m1_xfer : m0_xfer;
	assign grant = {busy & owner, busy & ~owner};

	// route the addressed slave's answer back
	always_comb begin
		if (s_xfer.slave == bus_pkg::slave_sel_t'(1)) begin
			slave_done  = s1_done;
			slave_rdata = s1_rdata;
		end else begin
			slave_done  = s0_done;
			slave_rdata = s0_rdata;
		end
	end

	assign m0_done = grant[0] & slave_done;
	assign m1_done = grant[1] & slave_done;
	assign m0_rsp.rdata = slave_rdata;
	assign m1_rsp.rdata = slave_rdata;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			busy        <= 1'b0;
			owner       <= 1'b0;
			// master 0 wins the first tie
			last_winner <= 1'b1;
			s0_strobe   <= 1'b0;
			s1_strobe   <= 1'b0;
		end else begin
			s0_strobe <= 1'b0;
			s1_strobe <= 1'b0;
			if (!busy) begin
				if (any_request) begin
					busy        <= 1'b1;
					owner       <= pick;
					last_winner <= pick;
					s0_strobe   <= (pick_xfer.slave == bus_pkg::slave_sel_t'(0));
					s1_strobe   <= (pick_xfer.slave == bus_pkg::slave_sel_t'(1));
				end
			end else if (slave_done) begin
				// free again from the next cycle
				busy <= 1'b0;
			end
		end
	end

endmodule

//--- verilog/bus_master_port.sv
// module bus_master_port that turns one four-phase command into one bus transfer

`timescale 1ns/100ps

module bus_master_port (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           req,
	input  bus_pkg::cmd_t  cmd,
	output logic           ack,
	output bus_pkg::rsp_t  rsp,
	output logic           bus_request,
	output bus_pkg::xfer_t xfer,
	input  logic           bus_done,
	input  bus_pkg::rsp_t  bus_rsp
);

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_REQUEST,
		ST_WAIT_DONE,
		ST_ACK_HIGH,
		ST_WAIT_RELEASE
	} state_t;

	state_t state;
	logic   on_bus;

	// request stays up from the first bus cycle until done
	assign on_bus = (state == ST_REQUEST) || (state == ST_WAIT_DONE);
	assign bus_request = on_bus;

	// ack covers the first cycle and the wait for req to fall
	assign ack = (state == ST_ACK_HIGH) || (state == ST_WAIT_RELEASE);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state <= ST_IDLE;
		end else begin
			case (state)
				ST_IDLE: begin
					if (req) begin
						state <= ST_REQUEST;
					end
				end
				// arbiter samples the new request in this cycle
				ST_REQUEST: begin
					state <= ST_WAIT_DONE;
				end
				ST_WAIT_DONE: begin
					if (bus_done) begin
						state <= ST_ACK_HIGH;
					end
				end
				ST_ACK_HIGH: begin
					state <= req ? ST_WAIT_RELEASE : ST_IDLE;
				end
				// outside still holds req, bus already released
				ST_WAIT_RELEASE: begin
					if (!req) begin
						state <= ST_IDLE;
					end
				end
				default: begin
					state <= ST_IDLE;
				end
			endcase
		end
	end

	// command copy, so cmd may change once ack is seen
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && req) begin
			xfer.write <= cmd.write;
			xfer.slave <= cmd.slave;
			xfer.addr  <= cmd.addr;
			xfer.wdata <= cmd.wdata;
		end
	end

	// response held for the whole ack phase
	always_ff @(posedge clk) begin
		if (on_bus && bus_done) begin
			rsp <= bus_rsp;
		end
	end

endmodule

//--- verilog/bus_pkg.sv
// package bus_pkg with bus widths and the command, transfer and response structs

package bus_pkg;

	// word address inside one slave
	localparam int ADDR_W = 10;
	localparam int DATA_W = 8;
	localparam int NUM_SLAVES = 2;

	// one bit picks slave 0 or slave 1
	typedef logic [$clog2(NUM_SLAVES)-1:0] slave_sel_t;

	// command as it arrives on a master's outside port
	typedef struct packed {
		logic              write;
		slave_sel_t        slave;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} cmd_t;

	// transfer from a master port through the arbiter to a slave
	// slave field is only looked at by the arbiter
	typedef struct packed {
		logic              write;
		slave_sel_t        slave;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} xfer_t;

	// response back to the master
	// writes return the word as it was before the write
	typedef struct packed {
		logic [DATA_W-1:0] rdata;
	} rsp_t;

endpackage

//--- verilog/bus_system.sv
// module bus_system with two master ports, the bus arbiter and two memory slaves

`timescale 1ns/100ps

module bus_system #(
	parameter int unsigned SLAVE0_DELAY = 0,
	parameter int unsigned SLAVE1_DELAY = 10
) (
	input  logic          clk,
	input  logic          rst_n,
	input  logic          req0,
	input  logic          req1,
	input  bus_pkg::cmd_t cmd0,
	input  bus_pkg::cmd_t cmd1,
	output logic          ack0,
	output logic          ack1,
	output bus_pkg::rsp_t rsp0,
	output bus_pkg::rsp_t rsp1
);

	// master side of the bus
	logic           m0_request;
	logic           m1_request;
	bus_pkg::xfer_t m0_xfer;
	bus_pkg::xfer_t m1_xfer;
	logic           m0_done;
	logic           m1_done;
	bus_pkg::rsp_t  m0_rsp;
	bus_pkg::rsp_t  m1_rsp;

	// slave side
	logic                       s0_strobe;
	logic                       s1_strobe;
	bus_pkg::xfer_t             s_xfer;
	logic                       s0_done;
	logic                       s1_done;
	logic [bus_pkg::DATA_W-1:0] s0_rdata;
	logic [bus_pkg::DATA_W-1:0] s1_rdata;

	bus_master_port u_master0 (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req0),
		.cmd         (cmd0),
		.ack         (ack0),
		.rsp         (rsp0),
		.bus_request (m0_request),
		.xfer        (m0_xfer),
		.bus_done    (m0_done),
		.bus_rsp     (m0_rsp)
	);

	bus_master_port u_master1 (
		.clk         (clk),
		.rst_n       (rst_n),
		.req         (req1),
		.cmd         (cmd1),
		.ack         (ack1),
		.rsp         (rsp1),
		.bus_request (m1_request),
		.xfer        (m1_xfer),
		.bus_done    (m1_done),
		.bus_rsp     (m1_rsp)
	);

	bus_arbiter u_arbiter (
		.clk        (clk),
		.rst_n      (rst_n),
		.m0_request (m0_request),
		.m1_request (m1_request),
		.m0_xfer    (m0_xfer),
		.m1_xfer    (m1_xfer),
		.m0_done    (m0_done),
		.m1_done    (m1_done),
		.m0_rsp     (m0_rsp),
		.m1_rsp     (m1_rsp),
		.s0_strobe  (s0_strobe),
		.s1_strobe  (s1_strobe),
		.s_xfer     (s_xfer),
		.s0_done    (s0_done),
		.s1_done    (s1_done),
		.s0_rdata   (s0_rdata),
		.s1_rdata   (s1_rdata)
	);

	// both slaves see the shared xfer, only the strobed one acts
	mem_slave #(.SLAVE_DELAY(SLAVE0_DELAY)) u_slave0 (
		.clk    (clk),
		.rst_n  (rst_n),
		.strobe (s0_strobe),
		.xfer   (s_xfer),
		.done   (s0_done),
		.rdata  (s0_rdata)
	);

	mem_slave #(.SLAVE_DELAY(SLAVE1_DELAY)) u_slave1 (
		.clk    (clk),
		.rst_n  (rst_n),
		.strobe (s1_strobe),
		.xfer   (s_xfer),
		.done   (s1_done),
		.rdata  (s1_rdata)
	);

endmodule

//--- verilog/mem_slave.sv
// module mem_slave, a 1024-word memory that answers after a fixed delay

`timescale 1ns/100ps

module mem_slave #(
	parameter int unsigned SLAVE_DELAY = 0
) (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       strobe,
	input  bus_pkg::xfer_t             xfer,
	output logic                       done,
	output logic [bus_pkg::DATA_W-1:0] rdata
);

	localparam int unsigned DEPTH = 1 << bus_pkg::ADDR_W;

	logic [bus_pkg::DATA_W-1:0] mem [DEPTH];
	logic [3:0]                 delay_cnt;

	// counts down the answer delay, done fires as it reaches zero
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			done      <= 1'b0;
			delay_cnt <= 4'd0;
		end else begin
			done <= 1'b0;
			if (strobe) begin
				if (SLAVE_DELAY == 0) begin
					done <= 1'b1;
				end else begin
					delay_cnt <= 4'(SLAVE_DELAY);
				end
			end else if (delay_cnt != 4'd0) begin
				delay_cnt <= delay_cnt - 4'd1;
				if (delay_cnt == 4'd1) begin
					done <= 1'b1;
				end
			end
		end
	end

	// old word is captured in the same edge as the write
	always_ff @(posedge clk) begin
		if (strobe) begin
			rdata <= mem[xfer.addr];
			if (xfer.write) begin
				mem[xfer.addr] <= xfer.wdata;
			end
		end
	end

endmodule
